// File: aw_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module aw_arbiter (
	input wire ACLK,
	input wire ARESETn,
	input wire axi_pkg::aw_req_t [1:0] m_aw,
	input wire [1:0] m_awvalid,
	output logic [1:0] m_awready,
	output axi_pkg::aw_bus_t s_aw,
	output logic [axi_pkg::NUM_SLAVES-1:0] s_awvalid,
	input wire [axi_pkg::NUM_SLAVES-1:0] s_awready,
	input wire last_beat_done,
	input wire done,
	output logic grant,
	output axi_pkg::slv_sel_t sel,
	output logic data_phase,
	output logic resp_phase
);

	import axi_pkg::*;

	// one write in flight, phases run in order
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_RESP
	} state_t;

	state_t state;
	state_t state_n;
	// master preferred on the next tie
	logic prio;
	logic win;
	logic take;
	aw_req_t req_q;
	logic addr_ready;
	logic aw_hs;

	// offset compare, also works for a base of zero
	function automatic logic in_range(input logic [ADDR_BITS-1:0] addr,
		input logic [ADDR_BITS-1:0] base, input logic [ADDR_BITS-1:0] last);
		return (addr - base) <= (last - base);
	endfunction

	// tie goes to prio, otherwise the lone requester
	always_comb begin
		if (m_awvalid == 2'b11)
			win = prio;
		else
			win = m_awvalid[1];
	end

	assign take = (state == ST_IDLE) && (|m_awvalid);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= ST_IDLE;
			grant <= 1'b0;
			// m0 first out of reset
			prio <= 1'b0;
		end else begin
			state <= state_n;
			if (take) begin
				grant <= win;
				prio <= ~win;
			end
		end
	end

	// request held for the whole write so decode stays put
	always_ff @(posedge ACLK) begin
		if (take)
			req_q <= m_aw[win];
	end

	// decode latched address
	always_comb begin
		if (in_range(req_q.addr, SLV0_BASE, SLV0_LAST))
			sel = 2'd0;
		else if (in_range(req_q.addr, SLV1_BASE, SLV1_LAST))
			sel = 2'd1;
		else if (in_range(req_q.addr, SLV2_BASE, SLV2_LAST))
			sel = 2'd2;
		else
			sel = SEL_NONE;
	end

	// unmapped aw is taken here at once
	always_comb begin
		addr_ready = 1'b1;
		for (int i = 0; i < NUM_SLAVES; i++) begin
			if (sel == slv_sel_t'(i))
				addr_ready = s_awready[i];
		end
	end

	assign aw_hs = (state == ST_ADDR) && m_awvalid[grant] && addr_ready;

	always_comb begin
		state_n = state;
		case (state)
			ST_IDLE: if (|m_awvalid) state_n = ST_ADDR;
			ST_ADDR: if (aw_hs) state_n = ST_DATA;
			ST_DATA: if (last_beat_done) state_n = ST_RESP;
			ST_RESP: if (done) state_n = ST_IDLE;
			default: state_n = ST_IDLE;
		endcase
	end

	// bus id, master index prefixed
	always_comb begin
		s_aw.id = {grant, req_q.id};
		s_aw.addr = req_q.addr;
		s_aw.len = req_q.len;
		s_aw.size = req_q.size;
		s_aw.burst = req_q.burst;
	end

	// valid to one slave, ready back to the granted master only
	always_comb begin
		for (int i = 0; i < NUM_SLAVES; i++)
			s_awvalid[i] = (state == ST_ADDR) && m_awvalid[grant] && (sel == slv_sel_t'(i));
		for (int m = 0; m < 2; m++)
			m_awready[m] = (state == ST_ADDR) && (grant == 1'(m)) && addr_ready;
	end

	assign data_phase = (state == ST_DATA);
	assign resp_phase = (state == ST_RESP);

	// never two slaves addressed at once
	a_one_slave: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$onehot0(s_awvalid));

	// grant only moves between transactions
	a_grant_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		(state != ST_IDLE) |=> $stable(grant));

endmodule

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

	// master side id width
	localparam int ID_BITS = 4;
	// slave side id, master index on top of master id
	localparam int BUS_ID_BITS = ID_BITS + 1;
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32;
	localparam int STRB_BITS = DATA_BITS / 8;
	localparam int LEN_BITS = 4;
	localparam int SIZE_BITS = 3;
	localparam int NUM_SLAVES = 3;

	// bresp codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// address map, bounds inclusive
	localparam logic [ADDR_BITS-1:0] SLV0_BASE = 32'h0000_0000;
	localparam logic [ADDR_BITS-1:0] SLV0_LAST = 32'h0000_FFFF;
	localparam logic [ADDR_BITS-1:0] SLV1_BASE = 32'h1000_0000;
	localparam logic [ADDR_BITS-1:0] SLV1_LAST = 32'h1FFF_FFFF;
	localparam logic [ADDR_BITS-1:0] SLV2_BASE = 32'h2000_0000;
	localparam logic [ADDR_BITS-1:0] SLV2_LAST = 32'h2FFF_FFFF;

	// slave index, 3 is the unmapped hole
	typedef logic [1:0] slv_sel_t;
	localparam slv_sel_t SEL_NONE = 2'd3;

	// aw as seen by a master
	typedef struct packed {
		logic [ID_BITS-1:0] id;
		logic [ADDR_BITS-1:0] addr;
		logic [LEN_BITS-1:0] len;
		logic [SIZE_BITS-1:0] size;
		logic [1:0] burst;
	} aw_req_t;

	// aw as seen by a slave, wider id
	typedef struct packed {
		logic [BUS_ID_BITS-1:0] id;
		logic [ADDR_BITS-1:0] addr;
		logic [LEN_BITS-1:0] len;
		logic [SIZE_BITS-1:0] size;
		logic [1:0] burst;
	} aw_bus_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic [STRB_BITS-1:0] strb;
		logic last;
	} w_beat_t;

	// same word on both sides, masters look at low ID_BITS
	typedef struct packed {
		logic [BUS_ID_BITS-1:0] id;
		logic [1:0] resp;
	} b_resp_t;

endpackage

`default_nettype wire

// File: axi_write_xbar.sv
`timescale 1ns/1ns
`default_nettype none

module axi_write_xbar (
	input wire ACLK,
	input wire ARESETn,
	// master ports
	input wire axi_pkg::aw_req_t [1:0] m_aw,
	input wire [1:0] m_awvalid,
	output logic [1:0] m_awready,
	input wire axi_pkg::w_beat_t [1:0] m_w,
	input wire [1:0] m_wvalid,
	output logic [1:0] m_wready,
	output axi_pkg::b_resp_t m_b,
	output logic [1:0] m_bvalid,
	input wire [1:0] m_bready,
	// slave ports
	output axi_pkg::aw_bus_t s_aw,
	output logic [axi_pkg::NUM_SLAVES-1:0] s_awvalid,
	input wire [axi_pkg::NUM_SLAVES-1:0] s_awready,
	output axi_pkg::w_beat_t s_w,
	output logic [axi_pkg::NUM_SLAVES-1:0] s_wvalid,
	input wire [axi_pkg::NUM_SLAVES-1:0] s_wready,
	input wire axi_pkg::b_resp_t [axi_pkg::NUM_SLAVES-1:0] s_b,
	input wire [axi_pkg::NUM_SLAVES-1:0] s_bvalid,
	output logic [axi_pkg::NUM_SLAVES-1:0] s_bready
);

	import axi_pkg::*;

	// transaction state shared by both routers
	logic grant;
	slv_sel_t sel;
	logic data_phase;
	logic resp_phase;
	logic last_beat_done;
	logic done;

	aw_arbiter u_aw_arbiter (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.m_aw(m_aw),
		.m_awvalid(m_awvalid),
		.m_awready(m_awready),
		.s_aw(s_aw),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.last_beat_done(last_beat_done),
		.done(done),
		.grant(grant),
		.sel(sel),
		.data_phase(data_phase),
		.resp_phase(resp_phase)
	);

	// len and bus id come from the latched request on s_aw
	w_router u_w_router (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.m_w(m_w),
		.m_wvalid(m_wvalid),
		.m_wready(m_wready),
		.s_w(s_w),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.grant(grant),
		.sel(sel),
		.data_phase(data_phase),
		.len(s_aw.len),
		.last_beat_done(last_beat_done)
	);

	b_router u_b_router (
		.ACLK(ACLK),
		.ARESETn(ARESETn),
		.s_b(s_b),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.m_b(m_b),
		.m_bvalid(m_bvalid),
		.m_bready(m_bready),
		.grant(grant),
		.sel(sel),
		.resp_phase(resp_phase),
		.bus_id(s_aw.id),
		.done(done)
	);

endmodule

`default_nettype wire

// File: b_router.sv
`timescale 1ns/1ns
`default_nettype none

module b_router (
	input wire ACLK,
	input wire ARESETn,
	input wire axi_pkg::b_resp_t [axi_pkg::NUM_SLAVES-1:0] s_b,
	input wire [axi_pkg::NUM_SLAVES-1:0] s_bvalid,
	output logic [axi_pkg::NUM_SLAVES-1:0] s_bready,
	output axi_pkg::b_resp_t m_b,
	output logic [1:0] m_bvalid,
	input wire [1:0] m_bready,
	input wire grant,
	input wire axi_pkg::slv_sel_t sel,
	input wire resp_phase,
	input wire [axi_pkg::BUS_ID_BITS-1:0] bus_id,
	output logic done
);

	import axi_pkg::*;

	// decerr valid for the unmapped case
	logic err_q;
	logic mapped;
	logic src_valid;
	logic b_hs;

	assign mapped = (sel != SEL_NONE);

	// selected slave, else the local decerr word
	always_comb begin
		m_b.id = bus_id;
		m_b.resp = RESP_DECERR;
		src_valid = err_q;
		for (int i = 0; i < NUM_SLAVES; i++) begin
			if (sel == slv_sel_t'(i)) begin
				m_b = s_b[i];
				src_valid = s_bvalid[i];
			end
		end
	end

	always_comb begin
		for (int m = 0; m < 2; m++)
			m_bvalid[m] = resp_phase && (grant == 1'(m)) && src_valid;
		// bready passes through from the granted master
		for (int i = 0; i < NUM_SLAVES; i++)
			s_bready[i] = resp_phase && (sel == slv_sel_t'(i)) && m_bready[grant];
	end

	assign b_hs = resp_phase && src_valid && m_bready[grant];
	assign done = b_hs;

	// raised one cycle into resp, dropped on the handshake
	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			err_q <= 1'b0;
		else if (b_hs)
			err_q <= 1'b0;
		else if (resp_phase && !mapped)
			err_q <= 1'b1;
	end

	// no response outside resp phase
	a_b_in_resp: assert property (@(posedge ACLK) disable iff (!ARESETn)
		!resp_phase |-> (m_bvalid == 2'b00));

	// arbiter leaves resp right after done
	a_done_ends: assert property (@(posedge ACLK) disable iff (!ARESETn)
		done |=> !resp_phase);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the log holds the pass line
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	-f verilog.f --top-module tb_axi_write_xbar -o sim \
	&& ./obj_dir/sim > sim.log \
	; cat sim.log 2>/dev/null \
	; grep -q "^Simulation PASSED$" sim.log \
	|| { echo "simulation did not pass"; exit 1; }

// File: tb_axi_write_xbar.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_write_xbar;

	import axi_pkg::*;

	localparam int CLK_PERIOD = 4;
	// rough cycle budget per test, in run order
	localparam int TEST_CYCLES = 30 + 40 + 160 + 30 + 120;
	// margin of four over the budget
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 4;

	logic ACLK;
	logic ARESETn;
	aw_req_t [1:0] m_aw;
	logic [1:0] m_awvalid;
	logic [1:0] m_awready;
	w_beat_t [1:0] m_w;
	logic [1:0] m_wvalid;
	logic [1:0] m_wready;
	b_resp_t m_b;
	logic [1:0] m_bvalid;
	logic [1:0] m_bready;
	aw_bus_t s_aw;
	logic [NUM_SLAVES-1:0] s_awvalid;
	logic [NUM_SLAVES-1:0] s_awready;
	w_beat_t s_w;
	logic [NUM_SLAVES-1:0] s_wvalid;
	logic [NUM_SLAVES-1:0] s_wready;
	b_resp_t [NUM_SLAVES-1:0] s_b;
	logic [NUM_SLAVES-1:0] s_bvalid;
	logic [NUM_SLAVES-1:0] s_bready;

	int errors = 0;
	int checks = 0;
	logic [31:0] lcg_state = 32'd89211;
	// fewer ready cycles when set
	logic stall_heavy = 1'b0;
	// everything the slave models took
	aw_bus_t aw_log[$];
	w_beat_t w_log[$];
	logic [NUM_SLAVES-1:0] awv_seen = '0;
	logic [NUM_SLAVES-1:0] wv_seen = '0;
	int b_count[2];
	// masters in order of their b handshake
	int done_order[$];
	// m0 has priority out of reset, same as m1 having won last
	int last_winner = 1;

	axi_write_xbar dut (.*);

	initial ACLK = 1'b0;
	always #(CLK_PERIOD / 2) ACLK = ~ACLK;

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// top bits only, low lcg bits repeat fast
	function automatic logic ready_draw();
		logic [31:0] r;
		r = rand_next();
		return stall_heavy ? r[30] : (r[30:29] != 2'b00);
	endfunction

	function automatic aw_req_t make_req(input logic [ID_BITS-1:0] id,
		input logic [ADDR_BITS-1:0] addr, input logic [LEN_BITS-1:0] len);
		aw_req_t r;
		r.id = id;
		r.addr = addr;
		r.len = len;
		r.size = 3'd2;
		r.burst = 2'b01;
		return r;
	endfunction

	// master index lands on top of the id
	function automatic aw_bus_t to_bus(input int m, input aw_req_t r);
		return aw_bus_t'({1'(m), r});
	endfunction

	function automatic w_beat_t make_beat(input int m, input int k, input int len);
		w_beat_t b;
		b.data = {4'hd, 12'(m), 16'(k)};
		b.strb = 4'hf;
		b.last = (k == len);
		return b;
	endfunction

	task automatic compare_aw(input aw_bus_t got, input aw_bus_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_w(input w_beat_t got, input w_beat_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_b(input b_resp_t got, input b_resp_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// handshake flag vectors
	task automatic compare_flags(input logic [14:0] got, input logic [14:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic clear_logs();
		aw_log.delete();
		w_log.delete();
		awv_seen = '0;
		wv_seen = '0;
	endtask

	// one full write from master m, starts just after a rising edge
	task automatic master_write(input int m, input aw_req_t req, input logic [1:0] resp,
		input logic rand_bready);
		b_resp_t got;
		b_resp_t exp;
		m_aw[m] = req;
		m_awvalid[m] = 1'b1;
		@(negedge ACLK);
		while (!m_awready[m])
			@(negedge ACLK);
		@(posedge ACLK);
		#1;
		m_awvalid[m] = 1'b0;
		for (int k = 0; k <= int'(req.len); k++) begin
			m_w[m] = make_beat(m, k, int'(req.len));
			m_wvalid[m] = 1'b1;
			@(negedge ACLK);
			while (!m_wready[m])
				@(negedge ACLK);
			@(posedge ACLK);
			#1;
		end
		m_wvalid[m] = 1'b0;
		m_bready[m] = rand_bready ? ready_draw() : 1'b1;
		@(negedge ACLK);
		while (!(m_bvalid[m] && m_bready[m])) begin
			@(posedge ACLK);
			#1;
			m_bready[m] = rand_bready ? ready_draw() : 1'b1;
			@(negedge ACLK);
		end
		got = m_b;
		@(posedge ACLK);
		#1;
		m_bready[m] = 1'b0;
		exp.id = {1'(m), req.id};
		exp.resp = resp;
		compare_b(got, exp, $sformatf("b at master %0d", m));
		done_order.push_back(m);
		last_winner = m;
	endtask

	// slv equal to NUM_SLAVES means nobody should have seen it
	task automatic check_slave_side(input int slv, input int m, input aw_req_t req);
		logic [NUM_SLAVES-1:0] hit;
		int n_aw;
		int n_w;
		hit = (slv < NUM_SLAVES) ? NUM_SLAVES'(1 << slv) : '0;
		n_aw = (slv < NUM_SLAVES) ? 1 : 0;
		n_w = (slv < NUM_SLAVES) ? int'(req.len) + 1 : 0;
		compare_flags(15'({awv_seen, wv_seen}), 15'({hit, hit}), "slave valids seen");
		checks++;
		if (aw_log.size() != n_aw || w_log.size() != n_w) begin
			errors++;
			$display("slaves took %0d requests and %0d beats where %0d and %0d were due",
				aw_log.size(), w_log.size(), n_aw, n_w);
		end else begin
			for (int k = 0; k < n_aw; k++)
				compare_aw(aw_log[k], to_bus(m, req), "aw at slave");
			for (int k = 0; k < n_w; k++)
				compare_w(w_log[k], make_beat(m, k, int'(req.len)), $sformatf("w beat %0d", k));
		end
	endtask

	// slave models, random ready, okay with the received id
	initial begin
		logic [BUS_ID_BITS-1:0] id_q [NUM_SLAVES];
		logic [NUM_SLAVES-1:0] b_pend;
		logic rst_off;
		s_awready = '0;
		s_wready = '0;
		s_bvalid = '0;
		s_b = '0;
		b_pend = '0;
		forever begin
			@(negedge ACLK);
			rst_off = ARESETn;
			awv_seen = awv_seen | s_awvalid;
			wv_seen = wv_seen | s_wvalid;
			for (int i = 0; i < NUM_SLAVES; i++) begin
				if (s_awvalid[i] && s_awready[i]) begin
					aw_log.push_back(s_aw);
					id_q[i] = s_aw.id;
				end
				if (s_wvalid[i] && s_wready[i]) begin
					w_log.push_back(s_w);
					// response owed once the burst is in
					if (s_w.last)
						b_pend[i] = 1'b1;
				end
				if (s_bvalid[i] && s_bready[i])
					b_pend[i] = 1'b0;
			end
			for (int m = 0; m < 2; m++) begin
				if (m_bvalid[m] && m_bready[m])
					b_count[m]++;
			end
			@(posedge ACLK);
			#1;
			for (int i = 0; i < NUM_SLAVES; i++) begin
				s_awready[i] = rst_off && ready_draw();
				s_wready[i] = rst_off && ready_draw();
				s_bvalid[i] = b_pend[i];
				s_b[i].id = id_q[i];
				s_b[i].resp = RESP_OKAY;
			end
		end
	end

	// idle outputs, then one beat from m0 to slave 1
	task automatic test_single_write();
		aw_req_t req;
		compare_flags({m_awready, m_wready, m_bvalid, s_awvalid, s_wvalid, s_bready}, '0,
			"outputs after reset");
		req = make_req(4'h3, 32'h1000_0040, 4'd0);
		@(posedge ACLK);
		#1;
		clear_logs();
		master_write(0, req, RESP_OKAY, 1'b0);
		check_slave_side(1, 0, req);
	endtask

	task automatic test_burst_write();
		aw_req_t req;
		req = make_req(4'h5, 32'h2000_0100, 4'd3);
		@(posedge ACLK);
		#1;
		clear_logs();
		master_write(1, req, RESP_OKAY, 1'b0);
		check_slave_side(2, 1, req);
	endtask

	task automatic test_round_robin();
		int first;
		for (int round = 0; round < 2; round++) begin
			// tie goes to the master that lost last time
			first = (last_winner == 0) ? 1 : 0;
			done_order.delete();
			@(posedge ACLK);
			#1;
			fork
				master_write(0, make_req(4'h1, 32'h1000_0200, 4'd1), RESP_OKAY, 1'b0);
				master_write(1, make_req(4'h2, 32'h2000_0300, 4'd2), RESP_OKAY, 1'b0);
			join
			checks++;
			if (done_order.size() != 2 || done_order[0] != first ||
				done_order[1] != 1 - first) begin
				errors++;
				$display("round %0d finished out of turn, master %0d should have gone first",
					round, first);
			end
		end
	endtask

	task automatic test_unmapped_write();
		aw_req_t req;
		req = make_req(4'h9, 32'h4000_0000, 4'd1);
		@(posedge ACLK);
		#1;
		clear_logs();
		master_write(1, req, RESP_DECERR, 1'b1);
		check_slave_side(NUM_SLAVES, 1, req);
	endtask

	// heavy stalls on both sides
	task automatic test_stalled_burst();
		aw_req_t req;
		int b_before;
		req = make_req(4'h6, 32'h0000_1200, 4'd7);
		stall_heavy = 1'b1;
		@(posedge ACLK);
		#1;
		clear_logs();
		b_before = b_count[0];
		master_write(0, req, RESP_OKAY, 1'b1);
		// bready left open so a repeated response would be counted
		m_bready[0] = 1'b1;
		repeat (4) @(posedge ACLK);
		#1;
		m_bready[0] = 1'b0;
		stall_heavy = 1'b0;
		check_slave_side(0, 0, req);
		checks++;
		if (b_count[0] - b_before != 1) begin
			errors++;
			$display("master 0 took %0d responses for a single burst", b_count[0] - b_before);
		end
	endtask

	task automatic finish_run();
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	initial begin
		ARESETn = 1'b0;
		m_aw = '0;
		m_awvalid = '0;
		m_w = '0;
		m_wvalid = '0;
		m_bready = '0;
		repeat (7) @(posedge ACLK);
		@(negedge ACLK);
		compare_flags({m_awready, m_wready, m_bvalid, s_awvalid, s_wvalid, s_bready}, '0,
			"outputs in reset");
		@(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		@(negedge ACLK);
		test_single_write();
		test_burst_write();
		test_round_robin();
		test_unmapped_write();
		test_stalled_burst();
		finish_run();
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout, tests still running after %0d ns", WATCHDOG_NS);
		errors++;
		finish_run();
	end

endmodule

`default_nettype wire

// File: verilog.f
axi_pkg.sv
aw_arbiter.sv
w_router.sv
b_router.sv
axi_write_xbar.sv
tb_axi_write_xbar.sv

// File: w_router.sv
`timescale 1ns/1ns
`default_nettype none

module w_router (
	input wire ACLK,
	input wire ARESETn,
	input wire axi_pkg::w_beat_t [1:0] m_w,
	input wire [1:0] m_wvalid,
	output logic [1:0] m_wready,
	output axi_pkg::w_beat_t s_w,
	output logic [axi_pkg::NUM_SLAVES-1:0] s_wvalid,
	input wire [axi_pkg::NUM_SLAVES-1:0] s_wready,
	input wire grant,
	input wire axi_pkg::slv_sel_t sel,
	input wire data_phase,
	input wire [axi_pkg::LEN_BITS-1:0] len,
	output logic last_beat_done
);

	import axi_pkg::*;

	w_beat_t beat;
	logic beat_valid;
	logic sink_ready;
	logic beat_hs;
	// beats taken so far in this burst
	logic [LEN_BITS-1:0] beat_cnt;

	// granted master only
	assign beat = m_w[grant];
	assign beat_valid = data_phase && m_wvalid[grant];
	assign s_w = beat;

	// unmapped write drains into the sink, always ready
	always_comb begin
		sink_ready = 1'b1;
		for (int i = 0; i < NUM_SLAVES; i++) begin
			if (sel == slv_sel_t'(i))
				sink_ready = s_wready[i];
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_SLAVES; i++)
			s_wvalid[i] = beat_valid && (sel == slv_sel_t'(i));
		for (int m = 0; m < 2; m++)
			m_wready[m] = data_phase && (grant == 1'(m)) && sink_ready;
	end

	assign beat_hs = beat_valid && sink_ready;
	assign last_beat_done = beat_hs && beat.last;

	// restarts at zero after the last beat
	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			beat_cnt <= '0;
		else if (beat_hs)
			beat_cnt <= beat.last ? '0 : beat_cnt + 1'b1;
	end

	// last exactly on beat len+1
	a_last_on_len: assert property (@(posedge ACLK) disable iff (!ARESETn)
		beat_hs |-> (beat.last == (beat_cnt == len)));

endmodule

`default_nettype wire
